// ==== pipePkg.sv ====
// Shared widths and types for the memory-access part of the pipeline
package pipePkg;

	// Data memory geometry
	localparam int memWords       = 512;  // Depth in 32-bit words
	localparam int memIndexBits   = 9;    // log2(memWords)
	localparam int byteOffsetBits = 2;    // Byte address >> 2 gives word index

	// A full machine word
	// ALU results, store data, loaded data and write-back data all use this
	typedef logic [31:0] word_t;

	// Destination register number, 32 architectural registers
	typedef logic [4:0] regAddr_t;

	// Word index into the data memory
	typedef logic [memIndexBits-1:0] memIndex_t;

endpackage

// ==== exMemReg.sv ====
`timescale 1ns/10ps

// EX/MEM pipeline register
// Control bits clear on reset or flush so a bubble moves down the pipe
// Data fields load every cycle and carry no reset
module exMemReg (
	input  logic            CLK,
	input  logic            rstN,
	input  logic            flush,        // Turn the incoming instruction into a bubble
	input  pipePkg::word_t   aluResultIn,  // Byte address or arithmetic result
	input  pipePkg::word_t   storeDataIn,  // rt value for stores
	input  logic            memReadIn,
	input  logic            memWriteIn,
	input  logic            regWriteIn,
	input  logic            memToRegIn,
	input  pipePkg::regAddr_t writeRegIn,
	output pipePkg::word_t   aluResult,
	output pipePkg::word_t   storeData,
	output logic            memRead,
	output logic            memWrite,
	output logic            regWrite,
	output logic            memToReg,
	output pipePkg::regAddr_t writeReg
);

	// Control half of the register
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			memRead  <= 1'b0;  // No access out of reset
			memWrite <= 1'b0;
			regWrite <= 1'b0;
			memToReg <= 1'b0;
		end else if (flush) begin
			memRead  <= 1'b0;  // Bubble
			memWrite <= 1'b0;  // Flushed store must not reach memory
			regWrite <= 1'b0;
			memToReg <= 1'b0;
		end else begin
			memRead  <= memReadIn;
			memWrite <= memWriteIn;
			regWrite <= regWriteIn;
			memToReg <= memToRegIn;
		end
	end

	// Data half, loaded regardless of bubble
	always_ff @(posedge CLK) begin
		aluResult <= aluResultIn;
		storeData <= storeDataIn;
		writeReg  <= writeRegIn;  // Harmless when regWrite is low
	end

	// A write-back from memory only makes sense for a load
	// Otherwise memWbReg would pick up gated-zero read data
	memToRegNeedsRead: assert property (@(posedge CLK) disable iff (!rstN)
		memToReg |-> memRead)
		else $error("EX/MEM memToReg set without memRead");

endmodule

// ==== dataMemory.sv ====
`timescale 1ns/10ps

// Word-addressed data memory, 512 x 32
// Combinational read gated by memRead, write on the rising edge
// Contents have no reset
module dataMemory (
	input  logic          CLK,
	input  pipePkg::word_t address,    // Byte address from the ALU
	input  pipePkg::word_t writeData,  // Store data
	input  logic          memWrite,
	input  logic          memRead,
	output pipePkg::word_t readData
);

	pipePkg::word_t    mem [pipePkg::memWords];  // Storage array
	pipePkg::memIndex_t index;                  // Word index

	// Drop the byte offset, keep the index field
	assign index = address[pipePkg::byteOffsetBits +: pipePkg::memIndexBits];

	// Read path
	// Zero when no load is in MEM
	assign readData = memRead ? mem[index] : '0;

	// Write port
	// A store in MEM commits at the end of its cycle,
	// so a load in the next cycle already sees the new word
	always_ff @(posedge CLK) begin
		if (memWrite) begin
			mem[index] <= writeData;
		end
	end

	// Load and store are separate instructions, never both in MEM
	noReadWriteOverlap: assert property (@(posedge CLK)
		!(memRead && memWrite))
		else $error("Data memory read and write in the same cycle");

	// Word accesses only
	alignedAccess: assert property (@(posedge CLK)
		(memRead || memWrite) |-> (address[pipePkg::byteOffsetBits-1:0] == '0))
		else $error("Unaligned data memory access at %h", address);

	// Nothing above the index field, so the index stays below memWords
	inRangeAccess: assert property (@(posedge CLK)
		(memRead || memWrite) |->
			(address[31:pipePkg::byteOffsetBits+pipePkg::memIndexBits] == '0))
		else $error("Data memory access out of range at %h", address);

endmodule

// ==== memWbReg.sv ====
`timescale 1ns/10ps

// MEM/WB pipeline register
// Also holds the write-back mux in front of the register file
module memWbReg (
	input  logic            CLK,
	input  logic            rstN,
	input  pipePkg::word_t   readDataIn,   // Gated memory read data
	input  pipePkg::word_t   aluResultIn,  // ALU result passed through MEM
	input  logic            regWriteIn,
	input  logic            memToRegIn,
	input  pipePkg::regAddr_t writeRegIn,
	output logic            regWrite,     // Register file write enable
	output pipePkg::regAddr_t writeReg,     // Destination register
	output pipePkg::word_t   writeData     // Value to write back
);

	pipePkg::word_t readDataQ;   // Loaded word
	pipePkg::word_t aluResultQ;  // Registered ALU result
	logic          memToRegQ;   // Selects load data for write-back

	// Write-back controls
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			regWrite  <= 1'b0;  // No register write out of reset
			memToRegQ <= 1'b0;
		end else begin
			regWrite  <= regWriteIn;
			memToRegQ <= memToRegIn;
		end
	end

	// Payload
	always_ff @(posedge CLK) begin
		readDataQ  <= readDataIn;
		aluResultQ <= aluResultIn;
		writeReg   <= writeRegIn;
	end

	// Write-back select
	// Load data for lw, ALU result for everything else
	always_comb begin
		if (memToRegQ) begin
			writeData = readDataQ;
		end else begin
			writeData = aluResultQ;
		end
	end

endmodule

// ==== memAccessStage.sv ====
`timescale 1ns/10ps

// Memory-access part of the five-stage pipeline
// EX inputs -> EX/MEM -> data memory -> MEM/WB -> register file outputs
// Fixed latency of two edges from ex* inputs to wb* outputs
module memAccessStage (
	input  logic            CLK,
	input  logic            rstN,
	input  logic            exFlush,      // Bubble the instruction entering EX/MEM
	input  pipePkg::word_t   exAluResult,
	input  pipePkg::word_t   exStoreData,
	input  logic            exMemRead,
	input  logic            exMemWrite,
	input  logic            exRegWrite,
	input  logic            exMemToReg,
	input  pipePkg::regAddr_t exWriteReg,
	output logic            wbRegWrite,
	output pipePkg::regAddr_t wbWriteReg,
	output pipePkg::word_t   wbWriteData
);

	// MEM stage signals, all from EX/MEM
	pipePkg::word_t    memAluResult;  // Also the memory address
	pipePkg::word_t    memStoreData;
	logic             memMemRead;
	logic             memMemWrite;
	logic             memRegWrite;
	logic             memMemToReg;
	pipePkg::regAddr_t memWriteReg;
	pipePkg::word_t    readData;      // Memory output to MEM/WB

	exMemReg exMem (
		.CLK         (CLK),
		.rstN        (rstN),
		.flush       (exFlush),
		.aluResultIn (exAluResult),
		.storeDataIn (exStoreData),
		.memReadIn   (exMemRead),
		.memWriteIn  (exMemWrite),
		.regWriteIn  (exRegWrite),
		.memToRegIn  (exMemToReg),
		.writeRegIn  (exWriteReg),
		.aluResult   (memAluResult),
		.storeData   (memStoreData),
		.memRead     (memMemRead),
		.memWrite    (memMemWrite),
		.regWrite    (memRegWrite),
		.memToReg    (memMemToReg),
		.writeReg    (memWriteReg)
	);

	dataMemory dataMem (
		.CLK       (CLK),
		.address   (memAluResult),  // Byte address straight from the ALU
		.writeData (memStoreData),
		.memWrite  (memMemWrite),
		.memRead   (memMemRead),
		.readData  (readData)
	);

	memWbReg memWb (
		.CLK         (CLK),
		.rstN        (rstN),
		.readDataIn  (readData),
		.aluResultIn (memAluResult),
		.regWriteIn  (memRegWrite),
		.memToRegIn  (memMemToReg),
		.writeRegIn  (memWriteReg),
		.regWrite    (wbRegWrite),
		.writeReg    (wbWriteReg),
		.writeData   (wbWriteData)
	);

endmodule

// ==== memStageTb.sv ====
`timescale 1ns/10ps

// Testbench for the memory-access stage
// Vectors come from memStage_tests.txt, one instruction per line
// Each line's write-back result is checked two edges after it is driven
module memStageTb;

	localparam int maxVectors  = 256;  // Room in the vector array
	localparam int resetCycles = 16;
	localparam int latency     = 2;    // ex* inputs to wb* outputs

	// DUT inputs start idle
	logic              CLK         = 1'b0;
	logic              rstN        = 1'b0;  // Held low for resetCycles edges
	logic              exFlush     = 1'b0;
	pipePkg::word_t    exAluResult = '0;
	pipePkg::word_t    exStoreData = '0;
	logic              exMemRead   = 1'b0;
	logic              exMemWrite  = 1'b0;
	logic              exRegWrite  = 1'b0;
	logic              exMemToReg  = 1'b0;
	pipePkg::regAddr_t exWriteReg  = '0;

	// DUT outputs
	logic              wbRegWrite;
	pipePkg::regAddr_t wbWriteReg;
	pipePkg::word_t    wbWriteData;

	// One test line per entry with the columns of the file header
	logic [135:0] vectors [maxVectors];
	int numVectors = 0;
	int cycleLimit = 0;   // Set once the vectors are counted
	int cycleCount = 0;   // Rising edges so far
	bit endFound   = 1'b0;

	memAccessStage UUT (
		.CLK         (CLK),
		.rstN        (rstN),
		.exFlush     (exFlush),
		.exAluResult (exAluResult),
		.exStoreData (exStoreData),
		.exMemRead   (exMemRead),
		.exMemWrite  (exMemWrite),
		.exRegWrite  (exRegWrite),
		.exMemToReg  (exMemToReg),
		.exWriteReg  (exWriteReg),
		.wbRegWrite  (wbRegWrite),
		.wbWriteReg  (wbWriteReg),
		.wbWriteData (wbWriteData)
	);

	always #50 CLK = ~CLK;  // 100 ns period

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			failRun($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual));
		end
	endtask

	task automatic checkRegAddr(input string name, input pipePkg::regAddr_t expected,
		input pipePkg::regAddr_t actual);
		if (actual !== expected) begin
			failRun($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual));
		end
	endtask

	task automatic checkWord(input string name, input pipePkg::word_t expected,
		input pipePkg::word_t actual);
		if (actual !== expected) begin
			failRun($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual));
		end
	endtask

	function automatic logic [135:0] fetchVector(input int n);
		return vectors[n[7:0]];
	endfunction

	// Split a line onto the ex* inputs
	task automatic driveVector(input logic [135:0] vec);
		exFlush     <= vec[132];
		exMemRead   <= vec[128];
		exMemWrite  <= vec[124];
		exRegWrite  <= vec[120];
		exMemToReg  <= vec[116];
		exWriteReg  <= vec[112:108];
		exAluResult <= vec[107:76];
		exStoreData <= vec[75:44];
	endtask

	// Register number and data only matter when a write is expected
	task automatic checkVector(input logic [135:0] vec);
		checkBit("wbRegWrite", vec[40], wbRegWrite);
		if (vec[40]) begin
			checkRegAddr("wbWriteReg", vec[36:32], wbWriteReg);
			checkWord("wbWriteData", vec[31:0], wbWriteData);
		end
	endtask

	// Load the vectors and count up to the end marker line
	initial begin
		$readmemh("memStage_tests.txt", vectors);
		for (int n = 0; n < maxVectors; n++) begin
			if (!endFound && vectors[n[7:0]][135:132] == 4'hf) begin
				numVectors = n;
				endFound   = 1'b1;
			end
		end
		if (!endFound) begin
			failRun("Test file has no end marker line");
		end else if (numVectors == 0) begin
			failRun("Test file holds no vectors");
		end else begin
			cycleLimit = numVectors + resetCycles + 10;  // Reset, vectors, drain and slack
			$display("Loaded %0d test vectors", numVectors);
		end
	end

	// Reset and then one line per rising edge
	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			failRun($sformatf("Timeout after %0d cycles without finishing the vectors",
				cycleCount));
		end else if (cycleCount < resetCycles - 1) begin
			driveVector('0);
			exRegWrite <= 1'b1;  // Only reset keeps this off the write-back port
		end else if (cycleCount == resetCycles - 1) begin
			rstN <= 1'b1;  // Released after the last reset edge
			driveVector('0);
		end else if (cycleCount - resetCycles < numVectors) begin
			driveVector(fetchVector(cycleCount - resetCycles));
		end else begin
			driveVector('0);  // Idle while draining
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge CLK) begin
		if (cycleCount >= resetCycles && cycleCount <= resetCycles + latency) begin
			checkBit("wbRegWrite", 1'b0, wbRegWrite);  // Cleared by reset in both registers
		end else if (cycleCount > resetCycles + latency) begin
			checkVector(fetchVector(cycleCount - resetCycles - latency - 1));
			if (cycleCount - resetCycles - latency == numVectors) begin
				$display("STATUS: PASS");
				$finish;
			end
		end
	end

endmodule

// ==== memStage_tests.txt ====
// flush_memRead_memWrite_regWrite_memToReg_writeReg_aluResult_storeData_expRegWrite_expWriteReg_expWriteData
// expWriteReg and expWriteData count only when expRegWrite is 1, a line starting with F ends the list
// Idle after reset
0_0_0_0_0_00_00000000_00000000_0_00_00000000
0_0_0_0_0_00_00000000_00000000_0_00_00000000
0_0_0_0_0_00_00000000_00000000_0_00_00000000
// ALU results go straight to write-back
0_0_0_1_0_08_00000005_00000000_1_08_00000005
0_0_0_1_0_1F_DEADBEEF_00000000_1_1F_DEADBEEF
0_0_0_1_0_01_7FFFFFFF_00000000_1_01_7FFFFFFF
0_0_0_1_0_10_80000000_00000000_1_10_80000000
// Stores, no register write
0_0_1_0_0_00_00000000_11111111_0_00_00000000
0_0_1_0_0_00_00000004_22222222_0_00_00000000
0_0_1_0_0_00_00000100_33333333_0_00_00000000
0_0_1_0_0_00_000003FC_44444444_0_00_00000000
// Load each word back
0_1_0_1_1_02_00000000_00000000_1_02_11111111
0_1_0_1_1_03_00000004_00000000_1_03_22222222
0_1_0_1_1_04_00000100_00000000_1_04_33333333
0_1_0_1_1_05_000003FC_00000000_1_05_44444444
// Load right behind a store to the same word
0_0_1_0_0_00_00000200_CAFEF00D_0_00_00000000
0_1_0_1_1_06_00000200_00000000_1_06_CAFEF00D
// Mixed traffic on different words
0_0_1_0_0_00_00000040_0BADC0DE_0_00_00000000
0_1_0_1_1_07_00000004_00000000_1_07_22222222
0_0_1_0_0_00_00000044_12345678_0_00_00000000
0_0_0_1_0_09_00000044_00000000_1_09_00000044
0_1_0_1_1_0A_00000040_00000000_1_0A_0BADC0DE
0_1_0_1_1_0B_00000044_00000000_1_0B_12345678
0_0_1_0_0_00_00000000_55555555_0_00_00000000
0_1_0_1_1_0C_00000000_00000000_1_0C_55555555
// Flushed store leaves the old word
1_0_1_0_0_00_00000004_FFFF0000_0_00_00000000
0_1_0_1_1_0D_00000004_00000000_1_0D_22222222
// Flushed ALU op and flushed load write nothing
1_0_0_1_0_0E_00000077_00000000_0_00_00000000
1_1_0_1_1_0F_00000000_00000000_0_00_00000000
0_0_0_1_0_0E_00000078_00000000_1_0E_00000078
// Extreme values and the top word at 2044
0_0_1_0_0_00_00000008_00000000_0_00_00000000
0_0_1_0_0_00_0000000C_FFFFFFFF_0_00_00000000
0_0_1_0_0_00_00000010_80000000_0_00_00000000
0_0_1_0_0_00_000007FC_A5A5A5A5_0_00_00000000
0_0_1_0_0_00_00000014_FFFFFFFE_0_00_00000000
0_1_0_1_1_11_00000008_00000000_1_11_00000000
0_1_0_1_1_12_0000000C_00000000_1_12_FFFFFFFF
0_1_0_1_1_13_00000010_00000000_1_13_80000000
0_1_0_1_1_14_000007FC_00000000_1_14_A5A5A5A5
0_1_0_1_1_15_00000014_00000000_1_15_FFFFFFFE
0_0_1_0_0_00_000007FC_5A5A5A5A_0_00_00000000
0_1_0_1_1_16_000007FC_00000000_1_16_5A5A5A5A
// Drain
0_0_0_0_0_00_00000000_00000000_0_00_00000000
0_0_0_0_0_00_00000000_00000000_0_00_00000000
// End marker
F_0_0_0_0_00_00000000_00000000_0_00_00000000

// ==== verilog.f ====
pipePkg.sv
exMemReg.sv
dataMemory.sv
memWbReg.sv
memAccessStage.sv
memStageTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the memory-access stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module memStageTb \
	-f verilog.f \
	-o memStageSim

./obj_dir/memStageSim
